/* hw/ahbPkg.sv */
// AHB slave port types and bus widths, imported by the bridge RTL and the testbench
`default_nettype none

package ahbPkg;

	localparam int DataWidth = 32;
	localparam int AddrWidth = 32;

	// Address bits that pick a byte lane inside one data word
	localparam int ByteLaneBits = $clog2(DataWidth / 8);

	// Transfer type on Htrans
	typedef enum logic [1:0]
	{
		TransIdle   = 2'b00,
		TransBusy   = 2'b01,
		TransNonseq = 2'b10,
		TransSeq    = 2'b11
	} htransE;

	// Transfer size on Hsize; wider codes are legal on the bus but move no data here
	typedef enum logic [2:0]
	{
		SizeByte = 3'b000,
		SizeHalf = 3'b001,
		SizeWord = 3'b010
	} hsizeE;

endpackage

`default_nettype wire

/* hw/apbPkg.sv */
// APB side of the bridge: peripheral map, sequencer states and the bus bundles built on them
`default_nettype none

package apbPkg;

	import ahbPkg::*;

	localparam int NumSlaves = 4;

	// Each peripheral owns one 4 KB window, starting at address zero
	localparam int SlaveWindowBits = 12;
	localparam int SlaveIdxBits = $clog2(NumSlaves);
	localparam int MapBits = SlaveWindowBits + SlaveIdxBits; // Anything above 16 KB misses

	// One-hot sequencer states
	typedef enum logic [5:0]
	{
		StIdle    = 6'b00_0001,
		StRead    = 6'b00_0010,
		StRenable = 6'b00_0100,
		StWwait   = 6'b00_1000,
		StWrite   = 6'b01_0000,
		StWenable = 6'b10_0000
	} bridgeStateE;

	// Registered AHB address phase together with its decoded peripheral
	typedef struct packed
	{
		logic [AddrWidth-1:0] addr;
		logic                 write;
		hsizeE                size;
		logic [NumSlaves-1:0] slaveSel;
	} ahbReqT;

	// APB master outputs
	typedef struct packed
	{
		logic [NumSlaves-1:0] sel;
		logic                 enable;
		logic                 write;
		logic [AddrWidth-1:0] addr;
		logic [DataWidth-1:0] wdata;
	} apbOutT;

endpackage

`default_nettype wire

/* hw/ahbCapture.sv */
// Bridge input stage: qualifies the AHB address phase, decodes the peripheral and registers it
`timescale 1ns/1ps
`default_nettype none

module ahbCapture import ahbPkg::*, apbPkg::*;
(
	input  wire logic                 Hclk,
	input  wire logic                 Hresetn,
	input  wire logic                 Hsel,
	input  wire logic [AddrWidth-1:0] Haddr,
	input  wire htransE               Htrans,
	input  wire logic                 Hwrite,
	input  wire hsizeE                Hsize,
	input  wire logic                 Hready,
	output logic                      start,
	output ahbReqT                    req
);

	logic                 valid;
	logic                 inMap;
	logic [NumSlaves-1:0] slaveSel;
	ahbReqT               reqNext;

	// Only NONSEQ and SEQ carry a transfer
	assign valid = Hsel && Hready && (Htrans == TransNonseq || Htrans == TransSeq);

	assign inMap = (Haddr[AddrWidth-1:MapBits] == '0);

	always_comb
	begin
		slaveSel = '0;
		if (inMap)
			slaveSel[Haddr[MapBits-1:SlaveWindowBits]] = 1'b1; // Window index
	end

	always_comb
	begin
		reqNext.addr = Haddr;
		reqNext.write = Hwrite;
		reqNext.size = Hsize;
		reqNext.slaveSel = slaveSel;
	end

	// High for the one cycle after the address phase
	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
			start <= 1'b0;
		else
			start <= valid;
	end

	// Held until the next accepted address phase
	always_ff @(posedge Hclk)
	begin
		if (valid)
			req <= reqNext;
	end

endmodule

`default_nettype wire

/* hw/bridgeFsm.sv */
// Bridge sequencer: steps through the APB setup and access phases and stalls AHB meanwhile
`timescale 1ns/1ps
`default_nettype none

module bridgeFsm import apbPkg::*;
(
	input  wire logic   Hclk,
	input  wire logic   Hresetn,
	input  wire logic   start,
	input  wire ahbReqT req,
	output bridgeStateE state,
	output logic        Hreadyout
);

	bridgeStateE nextState;
	bridgeStateE launchState;
	logic        readyState;

	// Direction of the request just captured
	assign launchState = req.write ? StWwait : StRead;

	always_comb
	begin
		nextState = state;
		unique case (state)
			StIdle:
			begin
				if (start)
					nextState = launchState;
			end
			StRead:
				nextState = StRenable;
			StRenable:
			begin
				if (start)
					nextState = launchState; // Back to back
				else
					nextState = StIdle;
			end
			StWwait:
				nextState = StWrite; // Write data arrives on Hwdata now
			StWrite:
				nextState = StWenable;
			StWenable:
			begin
				if (start)
					nextState = launchState;
				else
					nextState = StIdle;
			end
			default:
				nextState = StIdle;
		endcase
	end

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
			state <= StIdle;
		else
			state <= nextState;
	end

	assign readyState = (state == StIdle) || (state == StRenable) || (state == StWenable);

	// The capture cycle itself must not complete the data phase
	assign Hreadyout = readyState && !start;

endmodule

`default_nettype wire

/* hw/apbDriver.sv */
// Bridge output stage: APB strobes from the sequencer state plus byte lane steering both ways
`timescale 1ns/1ps
`default_nettype none

module apbDriver import ahbPkg::*, apbPkg::*;
(
	input  wire logic                 Hclk,
	input  wire logic                 Hresetn,
	input  wire bridgeStateE          state,
	input  wire ahbReqT               req,
	input  wire logic [DataWidth-1:0] Hwdata,
	input  wire logic [DataWidth-1:0] Prdata,
	output apbOutT                    apbOut,
	output logic [DataWidth-1:0]      Hrdata
);

	logic [DataWidth-1:0]    wdataReg;
	logic [ByteLaneBits-1:0] lane;
	logic                    selActive;
	logic                    writePhase;

	// Moves the addressed lane down to bit 0, zero filled
	function automatic logic [DataWidth-1:0] laneSelect(
		input hsizeE                   size,
		input logic [ByteLaneBits-1:0] offset,
		input logic [DataWidth-1:0]    data
	);
		logic [DataWidth-1:0] result;
		result = '0;
		case (size)
			SizeByte:
				result[7:0] = data[offset*8 +: 8];
			SizeHalf:
			begin
				if (!offset[0])
					result[15:0] = data[offset*8 +: 16];
			end
			SizeWord:
			begin
				if (offset == '0)
					result = data;
			end
			default:
				result = '0; // Unsupported size
		endcase
		return result;
	endfunction

	assign lane = req.addr[ByteLaneBits-1:0];

	// Hwdata is on the bus during the wait state
	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
			wdataReg <= '0;
		else if (state == StWwait)
			wdataReg <= Hwdata;
	end

	assign selActive = (state == StRead) || (state == StRenable) ||
		(state == StWrite) || (state == StWenable);
	assign writePhase = (state == StWrite) || (state == StWenable);

	always_comb
	begin
		apbOut.sel = selActive ? req.slaveSel : '0;
		apbOut.enable = (state == StRenable) || (state == StWenable);
		apbOut.write = writePhase;
		apbOut.addr = req.addr;
		apbOut.wdata = writePhase ? laneSelect(req.size, lane, wdataReg) : '0;
	end

	// Read data only in the access cycle
	assign Hrdata = (state == StRenable) ? laneSelect(req.size, lane, Prdata) : '0;

endmodule

`default_nettype wire

/* hw/ahbApbBridge.sv */
// AHB to APB bridge top level, connecting capture, sequencer and APB driver to the bus ports
`timescale 1ns/1ps
`default_nettype none

module ahbApbBridge import ahbPkg::*, apbPkg::*;
(
	input  wire logic                 Hclk,
	input  wire logic                 Hresetn,
	input  wire logic                 Hsel,
	input  wire logic [AddrWidth-1:0] Haddr,
	input  wire htransE               Htrans,
	input  wire logic                 Hwrite,
	input  wire hsizeE                Hsize,
	input  wire logic [DataWidth-1:0] Hwdata,
	input  wire logic                 Hready,
	output logic                      Hreadyout,
	output logic [DataWidth-1:0]      Hrdata,
	output logic [NumSlaves-1:0]      Psel,
	output logic                      Penable,
	output logic                      Pwrite,
	output logic [AddrWidth-1:0]      Paddr,
	output logic [DataWidth-1:0]      Pwdata,
	input  wire logic [DataWidth-1:0] Prdata
);

	logic        start;
	ahbReqT      req;
	bridgeStateE state;
	apbOutT      apbOut;

	ahbCapture capture
	(
		.Hclk    (Hclk),
		.Hresetn (Hresetn),
		.Hsel    (Hsel),
		.Haddr   (Haddr),
		.Htrans  (Htrans),
		.Hwrite  (Hwrite),
		.Hsize   (Hsize),
		.Hready  (Hready),
		.start   (start),
		.req     (req)
	);

	bridgeFsm sequencer
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.start     (start),
		.req       (req),
		.state     (state),
		.Hreadyout (Hreadyout)
	);

	apbDriver driver
	(
		.Hclk    (Hclk),
		.Hresetn (Hresetn),
		.state   (state),
		.req     (req),
		.Hwdata  (Hwdata),
		.Prdata  (Prdata),
		.apbOut  (apbOut),
		.Hrdata  (Hrdata)
	);

	assign Psel = apbOut.sel;
	assign Penable = apbOut.enable;
	assign Pwrite = apbOut.write;
	assign Paddr = apbOut.addr;
	assign Pwdata = apbOut.wdata;

endmodule

`default_nettype wire

/* tb/clockGen.sv */
// Testbench clock and reset source for the bridge, 100 ns clock with reset held for two cycles
`timescale 1ns/1ps
`default_nettype none

module clockGen
(
	output logic Hclk,
	output logic Hresetn
);

	initial
	begin
		Hclk = 1'b0;
		forever #50 Hclk = ~Hclk; // 100 ns period
	end

	initial
	begin
		Hresetn = 1'b0;
		repeat (2) @(posedge Hclk);
		Hresetn <= 1'b1;
	end

endmodule

`default_nettype wire

/* tb/bridgeTb.sv */
// Testbench top for the AHB to APB bridge: AHB master stimulus, APB peripheral model, assertions
`timescale 1ns/1ps
`default_nettype none

module bridgeTb import ahbPkg::*, apbPkg::*;
();

	localparam logic [31:0] Seed = 32'h76b88b78;
	localparam logic [31:0] ReadMask = 32'hA5A5_5A5A; // Peripheral returns Paddr xor this
	localparam int CycleLimit = 2 * 6 * 40 * 4 + 80; // 6 tests of 40 transfers, 4 cycles each

	logic                 Hclk;
	logic                 Hresetn;
	logic                 Hsel;
	logic [AddrWidth-1:0] Haddr;
	htransE               Htrans;
	logic                 Hwrite;
	hsizeE                Hsize;
	logic [DataWidth-1:0] Hwdata;
	logic                 Hready;
	logic                 Hreadyout;
	logic [DataWidth-1:0] Hrdata;
	logic [NumSlaves-1:0] Psel;
	logic                 Penable;
	logic                 Pwrite;
	logic [AddrWidth-1:0] Paddr;
	logic [DataWidth-1:0] Pwdata;
	logic [DataWidth-1:0] Prdata;

	logic                 accept;
	logic                 readAccept;
	logic                 writeAccept;
	logic                 readySample;
	logic                 seenAccept;
	logic                 wdataDue;
	logic [AddrWidth-1:0] expAddr;
	logic [2:0]           expSize;
	logic [NumSlaves-1:0] expSel;
	logic [DataWidth-1:0] expRdata;
	logic [DataWidth-1:0] expWdata;
	int                   errorCount;
	int                   testCount;
	int                   transferCount;
	int                   cycleCount;

	clockGen clocks
	(
		.Hclk    (Hclk),
		.Hresetn (Hresetn)
	);

	ahbApbBridge DUT
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.Hsel      (Hsel),
		.Haddr     (Haddr),
		.Htrans    (Htrans),
		.Hwrite    (Hwrite),
		.Hsize     (Hsize),
		.Hwdata    (Hwdata),
		.Hready    (Hready),
		.Hreadyout (Hreadyout),
		.Hrdata    (Hrdata),
		.Psel      (Psel),
		.Penable   (Penable),
		.Pwrite    (Pwrite),
		.Paddr     (Paddr),
		.Pwdata    (Pwdata),
		.Prdata    (Prdata)
	);

	assign Hready = Hreadyout; // Single slave on the bus
	assign accept = Hsel && Hready && (Htrans == TransNonseq || Htrans == TransSeq);
	assign readAccept = accept && !Hwrite;
	assign writeAccept = accept && Hwrite;

	// One 4 KB window per peripheral, nothing from 16 KB up
	function automatic logic [3:0] mapSel(input logic [31:0] addr);
		if (addr >= 32'h0000_4000)
			return 4'b0000;
		return 4'b0001 << (addr / 32'h1000);
	endfunction

	// Little endian lane picked by size and offset, shifted down and zero filled
	function automatic logic [31:0] steer(input logic [2:0] size, input logic [1:0] offset,
		input logic [31:0] word);
		logic [31:0] shifted;
		shifted = word >> (8 * offset);
		case (size)
			3'd0: return shifted & 32'h0000_00FF;
			3'd1: return offset[0] ? 32'h0 : (shifted & 32'h0000_FFFF);
			3'd2: return (offset == 2'd0) ? word : 32'h0;
			default: return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] readExpect(input logic [31:0] addr, input logic [2:0] size);
		if (mapSel(addr) == 4'b0000)
			return 32'h0; // No peripheral drives Prdata
		return steer(size, addr[1:0], addr ^ ReadMask);
	endfunction

	function automatic logic [31:0] inMapAddr();
		return $urandom % 32'h4000;
	endfunction

	function automatic logic [31:0] outMapAddr();
		return $urandom | 32'h0000_4000;
	endfunction

	// Mid cycle copy of Hreadyout, read by the master at the next edge
	always @(negedge Hclk)
		readySample = Hreadyout;

	always @(posedge Hclk)
	begin
		if (accept)
		begin
			seenAccept <= 1'b1;
			expAddr <= Haddr;
			expSize <= Hsize;
			expSel <= mapSel(Haddr);
			expRdata <= readExpect(Haddr, Hsize);
		end
		wdataDue <= writeAccept;
		if (wdataDue)
			expWdata <= steer(expSize, expAddr[1:0], Hwdata); // Hwdata of the data phase
	end

	// APB peripherals answer during the setup cycle
	always @(posedge Hclk)
		Prdata <= (Psel != 4'b0000) ? (Paddr ^ ReadMask) : 32'h0;

	always @(posedge Hclk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", CycleLimit);
			$display("Something failed");
			$finish;
		end
	end

	task automatic showMismatch(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		errorCount++;
		$display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
	endtask

	// Idle bus after reset
	assert property (@(posedge Hclk) disable iff (!Hresetn) !seenAccept |-> Hreadyout)
		else showMismatch("Hreadyout", $sampled(Hreadyout), 1);
	assert property (@(posedge Hclk) disable iff (!Hresetn) !seenAccept |-> Psel == 4'b0000)
		else showMismatch("Psel", $sampled(Psel), 0);
	assert property (@(posedge Hclk) disable iff (!Hresetn) !seenAccept |-> !Penable)
		else showMismatch("Penable", $sampled(Penable), 0);
	assert property (@(posedge Hclk) disable iff (!Hresetn) !seenAccept |-> !Pwrite)
		else showMismatch("Pwrite", $sampled(Pwrite), 0);
	assert property (@(posedge Hclk) disable iff (!Hresetn) $onehot0(Psel))
		else
		begin
			errorCount++;
			$display("More than one peripheral selected at %0t ns, Psel %b", $time, $sampled(Psel));
		end

	// Reads
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		readAccept |=> !Hreadyout ##1 !Hreadyout ##1 Hreadyout)
		else showMismatch("Hreadyout", $sampled(Hreadyout), !$sampled(Hreadyout));
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		readAccept |=> !Penable ##1 !Penable ##1 Penable)
		else showMismatch("Penable", $sampled(Penable), !$sampled(Penable));
	assert property (@(posedge Hclk) disable iff (!Hresetn) readAccept |=> Psel == 4'b0000)
		else showMismatch("Psel", $sampled(Psel), 0);
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		readAccept |=> ##1 (Psel == expSel) [*2])
		else showMismatch("Psel", $sampled(Psel), $sampled(expSel));
	assert property (@(posedge Hclk) disable iff (!Hresetn) readAccept |=> ##1 (!Pwrite) [*2])
		else showMismatch("Pwrite", $sampled(Pwrite), 0);
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		readAccept |=> ##1 (Paddr == expAddr) [*2])
		else showMismatch("Paddr", $sampled(Paddr), $sampled(expAddr));
	assert property (@(posedge Hclk) disable iff (!Hresetn) readAccept |=> ##2 Hrdata == expRdata)
		else showMismatch("Hrdata", $sampled(Hrdata), $sampled(expRdata));

	// Writes
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		writeAccept |=> (!Hreadyout) [*3] ##1 Hreadyout)
		else showMismatch("Hreadyout", $sampled(Hreadyout), !$sampled(Hreadyout));
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		writeAccept |=> (!Penable) [*3] ##1 Penable)
		else showMismatch("Penable", $sampled(Penable), !$sampled(Penable));
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		writeAccept |=> (Psel == 4'b0000) [*2])
		else showMismatch("Psel", $sampled(Psel), 0);
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		writeAccept |=> ##2 (Psel == expSel) [*2])
		else showMismatch("Psel", $sampled(Psel), $sampled(expSel));
	assert property (@(posedge Hclk) disable iff (!Hresetn) writeAccept |=> ##2 Pwrite [*2])
		else showMismatch("Pwrite", $sampled(Pwrite), 1);
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		writeAccept |=> ##2 (Paddr == expAddr) [*2])
		else showMismatch("Paddr", $sampled(Paddr), $sampled(expAddr));
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		writeAccept |=> ##2 (Pwdata == expWdata) [*2])
		else showMismatch("Pwdata", $sampled(Pwdata), $sampled(expWdata));

	task automatic reportTest(input int number, input string name, input int errorsBefore);
		testCount++;
		$display("Test %0d (%s) done, %0d errors", number, name, errorCount - errorsBefore);
	endtask

	// Steps to the edge that ends a cycle with Hreadyout high
	task automatic waitReady();
		do
			@(posedge Hclk);
		while (!readySample);
	endtask

	// Address phase, then the start of its data phase; returns on the accepting edge
	task automatic transfer(input logic [31:0] addr, input logic write, input logic [2:0] size,
		input logic seq);
		Hsel <= 1'b1;
		Htrans <= seq ? TransSeq : TransNonseq;
		Haddr <= addr;
		Hwrite <= write;
		Hsize <= hsizeE'(size);
		waitReady();
		Hwdata <= $urandom;
		transferCount++;
	endtask

	task automatic finishIdle();
		Hsel <= 1'b0;
		Htrans <= TransIdle;
		waitReady();
	endtask

	initial
	begin
		int errorsBefore;
		logic [31:0] addr;

		void'($urandom(Seed));
		Hsel = 1'b0;
		Haddr = '0;
		Htrans = TransIdle;
		Hwrite = 1'b0;
		Hsize = SizeWord;
		Hwdata = '0;
		Prdata = '0;
		readySample = 1'b0;
		seenAccept = 1'b0;
		wdataDue = 1'b0;
		expAddr = '0;
		expSize = '0;
		expSel = '0;
		expRdata = '0;
		expWdata = '0;
		errorCount = 0;
		testCount = 0;
		transferCount = 0;
		cycleCount = 0;
		wait (Hresetn);
		@(posedge Hclk);

		errorsBefore = errorCount;
		repeat (3) @(posedge Hclk);
		Hsel <= 1'b1;
		Htrans <= TransBusy; // Selected but no transfer
		Haddr <= inMapAddr();
		repeat (2) @(posedge Hclk);
		Htrans <= TransIdle;
		@(posedge Hclk);
		Hsel <= 1'b0;
		reportTest(1, "reset and idle bus", errorsBefore);

		errorsBefore = errorCount;
		for (int i = 0; i < 20; i++)
		begin
			transfer(inMapAddr() & ~32'h3, 1'b0, SizeWord, 1'b0);
			finishIdle();
		end
		reportTest(2, "word reads", errorsBefore);

		errorsBefore = errorCount;
		for (int i = 0; i < 20; i++)
		begin
			transfer(inMapAddr() & ~32'h3, 1'b1, SizeWord, 1'b0);
			finishIdle();
		end
		reportTest(3, "word writes", errorsBefore);

		errorsBefore = errorCount;
		for (int i = 0; i < 40; i++)
		begin
			transfer(inMapAddr(), 1'($urandom), 3'($urandom % 5), 1'b0);
			finishIdle();
		end
		reportTest(4, "sizes and lanes", errorsBefore);

		errorsBefore = errorCount;
		for (int i = 0; i < 10; i++)
		begin
			transfer(outMapAddr(), 1'($urandom), SizeWord, 1'b0);
			finishIdle();
		end
		reportTest(5, "unmapped addresses", errorsBefore);

		errorsBefore = errorCount;
		for (int i = 0; i < 40; i++)
		begin
			addr = ($urandom % 8 == 0) ? outMapAddr() : inMapAddr();
			transfer(addr, 1'($urandom), 3'($urandom % 3), i != 0);
		end
		finishIdle();
		reportTest(6, "back to back", errorsBefore);

		$display("Summary: %0d tests, %0d transfers, %0d errors", testCount, transferCount,
			errorCount);
		if (errorCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/ahbPkg.sv
hw/apbPkg.sv
hw/ahbCapture.sv
hw/bridgeFsm.sv
hw/apbDriver.sv
hw/ahbApbBridge.sv
tb/clockGen.sv
tb/bridgeTb.sv

/* Bender.yml */
package:
  name: ahbApbBridge

sources:
  - hw/ahbPkg.sv
  - hw/apbPkg.sv
  - hw/ahbCapture.sv
  - hw/bridgeFsm.sv
  - hw/apbDriver.sv
  - hw/ahbApbBridge.sv
  - target: test
    files:
      - tb/clockGen.sv
      - tb/bridgeTb.sv
